// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1; // release away from the edge
    end

endmodule

// ==== bench/tb_execute_top.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module tb_execute_top;
    import exe_op_pkg::*;
    import exe_bus_pkg::*;

    typedef struct packed {
        word_t alu_out;
        logic  hazard;
        word_t target;
    } expect_t;

    typedef logic [$bits(exe_ctrl_t)-1:0] value_t; // widest compared field

    // alu, branch, jump, gated branch, mul, div, flush
    localparam int NUM_INSTS = 200 + 30 + 4 + 4 + 40 + 40 + 2;
    localparam int LIMIT     = 40 * NUM_INSTS + 200;

    logic     clk;
    logic     arst_n;
    logic     exe_valid;
    exe_in_t  exe_in;
    logic     pipeline_flush;
    logic     mem_valid;
    exe_mem_t mem_out;
    logic     calc_stall;
    logic     branch_hazard;
    word_t    branch_target;

    logic [15:0] lfsr = 16'd83;
    inst_id_t    next_id = '0;
    string       test_name = "reset";
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycles = 0;

    word_t mul_a [4] = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    word_t mul_b [4] = '{32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};
    word_t div_a [4] = '{32'h1234_5678, 32'h8000_0000, 32'h0000_0007, 32'hffff_fff9};
    word_t div_b [4] = '{32'h0000_0000, 32'hffff_ffff, 32'hffff_fffe, 32'h0000_0002};

    clk_gen i_clk_gen (.clk(clk), .arst_n(arst_n));

    execute_top i_execute_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .exe_valid      (exe_valid),
        .exe_in         (exe_in),
        .pipeline_flush (pipeline_flush),
        .mem_valid      (mem_valid),
        .mem_out        (mem_out),
        .calc_stall     (calc_stall),
        .branch_hazard  (branch_hazard),
        .branch_target  (branch_target)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
    endfunction

    task automatic rand_bits(input int n, output word_t w);
        w = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic expect_t ref_model(input exe_in_t ins);
        expect_t     e;
        word_t       a;
        word_t       b;
        logic [63:0] p;
        logic        cond;
        a = ins.ctrl.op1_data;
        b = ins.ctrl.op2_data;
        e = '0;
        cond = 1'b0;
        case (ins.ctrl.exe_fun)
            ALU_ADD:    e.alu_out = a + b;
            ALU_SUB:    e.alu_out = a - b;
            ALU_AND:    e.alu_out = a & b;
            ALU_OR:     e.alu_out = a | b;
            ALU_XOR:    e.alu_out = a ^ b;
            ALU_SLL:    e.alu_out = a << b[4:0];
            ALU_SRL:    e.alu_out = a >> b[4:0];
            ALU_SRA:    e.alu_out = $signed(a) >>> b[4:0];
            ALU_SLT:    e.alu_out = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   e.alu_out = {31'b0, a < b};
            ALU_JALR:   e.alu_out = (a + b) & 32'hffff_fffe;
            ALU_COPY1:  e.alu_out = a;
            ALU_MUL: begin
                p = {32'b0, a} * {32'b0, b};
                e.alu_out = p[31:0];
            end
            ALU_MULH: begin
                p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                e.alu_out = p[63:32];
            end
            ALU_MULHU: begin
                p = {32'b0, a} * {32'b0, b};
                e.alu_out = p[63:32];
            end
            ALU_MULHSU: begin
                p = {{32{a[31]}}, a} * {32'b0, b};
                e.alu_out = p[63:32];
            end
            ALU_DIV, ALU_REM: begin
                if (b == '0) begin
                    e.alu_out = (ins.ctrl.exe_fun == ALU_DIV) ? '1 : a;
                end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    e.alu_out = (ins.ctrl.exe_fun == ALU_DIV) ? a : '0; // signed overflow
                end else if (ins.ctrl.exe_fun == ALU_DIV) begin
                    e.alu_out = $signed(a) / $signed(b);
                end else begin
                    e.alu_out = $signed(a) % $signed(b);
                end
            end
            ALU_DIVU:   e.alu_out = (b == '0) ? '1 : a / b;
            ALU_REMU:   e.alu_out = (b == '0) ? a : a % b;
            BR_BEQ:     cond = (a == b);
            BR_BNE:     cond = (a != b);
            BR_BLT:     cond = ($signed(a) < $signed(b));
            BR_BGE:     cond = ($signed(a) >= $signed(b));
            BR_BLTU:    cond = (a < b);
            BR_BGEU:    cond = (a >= b);
            default:    cond = 1'b0;
        endcase
        e.hazard = ins.ctrl.jmp_flg || cond;
        e.target = ins.reg_pc + (ins.ctrl.jmp_flg ? ins.ctrl.imm_j_sext : ins.ctrl.imm_b_sext);
        return e;
    endfunction

    task automatic check(input string what, input value_t expected, input value_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test();
        #1; // monitor is done with this negedge
        $display("test %s done, %0d errors", test_name, test_errors);
        test_errors = 0;
    endtask

    task automatic drive(input exe_fun_t fun, input word_t a, input word_t b,
                         input logic jmp, input logic valid);
        word_t w;
        @(posedge clk);
        #0.5;
        rand_bits(32, w);
        exe_in.reg_pc = w;
        rand_bits(32, w);
        exe_in.inst = w;
        rand_bits(32, w);
        exe_in.ctrl.rs2_data = w;
        rand_bits(32, w);
        exe_in.ctrl.imm_b_sext = w;
        rand_bits(32, w);
        exe_in.ctrl.imm_j_sext = w;
        exe_in.ctrl.exe_fun  = fun;
        exe_in.ctrl.op1_data = a;
        exe_in.ctrl.op2_data = b;
        exe_in.ctrl.jmp_flg  = jmp;
        exe_in.inst_id = next_id;
        next_id = next_id + 64'd1; // each instruction gets a fresh id
        exe_valid = valid;
        pipeline_flush = 1'b0;
    endtask

    task automatic run_single(input exe_fun_t fun, input word_t a, input word_t b,
                              input logic jmp, input logic valid);
        drive(fun, a, b, jmp, valid);
        @(negedge clk);
        check("mem_valid", word_t'(valid), word_t'(mem_valid));
        check("calc_stall", 0, word_t'(calc_stall));
    endtask

    task automatic run_multi(input exe_fun_t fun, input word_t a, input word_t b,
                             output int stalls);
        logic done;
        drive(fun, a, b, 1'b0, 1'b1);
        stalls = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (mem_valid && !calc_stall) begin
                done = 1'b1; // result compared by the monitor at this edge
            end else begin
                stalls++;
            end
        end
    endtask

    // monitor
    always @(negedge clk) begin
        expect_t e;
        if (arst_n) begin
            e = ref_model(exe_in);
            if (!exe_valid) begin
                check("branch_hazard idle", 0, word_t'(branch_hazard));
            end else begin
                check("branch_hazard", word_t'(e.hazard), word_t'(branch_hazard));
                check("branch_target", e.target, branch_target);
            end
            if (mem_valid) begin
                check("mem_out.reg_pc", exe_in.reg_pc, mem_out.reg_pc);
                check("mem_out.inst", exe_in.inst, mem_out.inst);
                check("mem_out.inst_id", exe_in.inst_id, mem_out.inst_id);
                check("mem_out.ctrl", exe_in.ctrl, mem_out.ctrl);
                if (exe_in.ctrl.exe_fun < BR_BEQ) begin
                    check("alu_out", e.alu_out, mem_out.alu_out);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        word_t a;
        word_t b;
        word_t w;
        int    stalls;
        exe_valid = 1'b0;
        exe_in = '0;
        pipeline_flush = 1'b0;

        @(posedge arst_n);
        @(negedge clk);
        check("mem_valid", 0, word_t'(mem_valid));
        check("calc_stall", 0, word_t'(calc_stall));
        check("branch_hazard", 0, word_t'(branch_hazard));
        report_test();

        test_name = "alu";
        repeat (200) begin
            rand_bits(4, w);
            rand_bits(32, a);
            rand_bits(32, b);
            run_single(exe_fun_t'(w % 12), a, b, 1'b0, 1'b1); // codes 0..11 are single cycle
        end
        report_test();

        test_name = "branch";
        for (exe_fun_t f = BR_BEQ; f <= BR_BGEU; f++) begin
            repeat (4) begin
                rand_bits(32, a);
                rand_bits(32, b);
                run_single(f, a, b, 1'b0, 1'b1);
            end
            run_single(f, a, a, 1'b0, 1'b1);
        end
        repeat (4) begin
            rand_bits(32, a);
            rand_bits(32, b);
            run_single(ALU_ADD, a, b, 1'b1, 1'b1);
            run_single(BR_BEQ, a, a, 1'b1, 1'b0); // taken branch with no valid
        end
        report_test();

        test_name = "mul";
        for (exe_fun_t f = ALU_MUL; f <= ALU_MULHSU; f++) begin
            for (int i = 0; i < 4; i++) begin
                run_multi(f, mul_a[i], mul_b[i], stalls);
            end
            repeat (6) begin
                rand_bits(32, a);
                rand_bits(32, b);
                run_multi(f, a, b, stalls);
            end
        end
        report_test();

        test_name = "div";
        for (exe_fun_t f = ALU_DIV; f <= ALU_REMU; f++) begin
            for (int i = 0; i < 4; i++) begin
                run_multi(f, div_a[i], div_b[i], stalls);
            end
            repeat (6) begin
                rand_bits(32, a);
                rand_bits(32, b);
                run_multi(f, a, b, stalls);
            end
        end
        report_test();

        test_name = "flush";
        rand_bits(32, a);
        rand_bits(32, b);
        drive(ALU_MUL, a, b, 1'b0, 1'b1);
        repeat (6) begin
            @(negedge clk);
            check("calc_stall", 1, word_t'(calc_stall));
        end
        @(posedge clk);
        #0.5;
        exe_valid = 1'b0;
        pipeline_flush = 1'b1;
        rand_bits(32, a);
        rand_bits(32, b);
        run_multi(ALU_DIVU, a, b, stalls);
        // the abandoned multiply finishes first, so an early end means its result leaked
        check("divide held full length", 1, word_t'(stalls > `MD_W));
        @(posedge clk);
        #0.5;
        exe_valid = 1'b0;
        report_test();

        repeat (2) @(posedge clk);
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic                 exe_valid,
    input  exe_bus_pkg::exe_in_t exe_in,
    output logic                 branch_hazard,
    output exe_op_pkg::word_t    branch_target
);
    import exe_op_pkg::*;
    import exe_bus_pkg::*;

    exe_ctrl_t ctrl;
    logic      br_taken;
    logic      eq;
    logic      lt_s;
    logic      lt_u;

    assign ctrl = exe_in.ctrl;
    assign eq   = (ctrl.op1_data == ctrl.op2_data);
    assign lt_s = ($signed(ctrl.op1_data) < $signed(ctrl.op2_data));
    assign lt_u = (ctrl.op1_data < ctrl.op2_data);

    always_comb begin
        case (ctrl.exe_fun)
            BR_BEQ:  br_taken = eq;
            BR_BNE:  br_taken = !eq;
            BR_BLT:  br_taken = lt_s;
            BR_BGE:  br_taken = !lt_s;
            BR_BLTU: br_taken = lt_u;
            BR_BGEU: br_taken = !lt_u;
            default: br_taken = 1'b0; // alu and muldiv codes
        endcase
    end

    assign branch_hazard = exe_valid && (ctrl.jmp_flg || br_taken);
    assign branch_target = exe_in.reg_pc + (ctrl.jmp_flg ? ctrl.imm_j_sext : ctrl.imm_b_sext);

endmodule

// ==== hw/div_unit.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module div_unit #(
    parameter int WIDTH = `MD_W
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  logic             is_signed,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             ready,
    output logic             valid,
    output logic             error,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);
    import exe_op_pkg::*;

    localparam int CNT_W = $clog2(WIDTH + 1);

    div_state_t       state;
    logic [CNT_W-1:0] count;
    logic             q_neg;
    logic             r_neg;
    logic             div_zero;
    logic [WIDTH-1:0] dividend_mag;
    logic [WIDTH-1:0] divisor_mag;
    logic [WIDTH-1:0] dvs;       // latched divisor magnitude
    logic [WIDTH-1:0] quo;       // dividend bits out at the top, quotient bits in at the bottom
    logic [WIDTH:0]   rem;
    logic [WIDTH:0]   rem_shift;
    logic             fits;
    logic             finish;

    assign ready        = (state == DIV_IDLE);
    // most negative value still reads right as an unsigned magnitude
    assign dividend_mag = (is_signed && dividend[WIDTH-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[WIDTH-1]) ? -divisor : divisor;
    assign rem_shift    = {rem[WIDTH-1:0], quo[WIDTH-1]};
    assign fits         = (rem_shift >= {1'b0, dvs});
    assign finish       = (state == DIV_BUSY) && (count == CNT_W'(WIDTH));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DIV_IDLE;
            count <= '0;
            valid <= 1'b0;
            error <= 1'b0;
        end else begin
            valid <= finish;
            error <= finish && div_zero;
            if (state == DIV_IDLE && start) begin
                state <= DIV_BUSY;
                count <= '0;
            end else if (finish) begin
                state <= DIV_IDLE;
            end else if (state == DIV_BUSY) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            q_neg    <= is_signed && (dividend[WIDTH-1] ^ divisor[WIDTH-1]);
            r_neg    <= is_signed && dividend[WIDTH-1]; // remainder follows dividend
            div_zero <= (divisor == '0);
            dvs      <= divisor_mag;
            quo      <= dividend_mag;
            rem      <= '0;
        end else if (finish) begin
            // zero divisor leaves rem at the dividend magnitude, so only quotient is forced
            quotient  <= div_zero ? '1 : (q_neg ? -quo : quo);
            remainder <= r_neg ? -rem[WIDTH-1:0] : rem[WIDTH-1:0];
        end else if (state == DIV_BUSY) begin
            rem <= fits ? rem_shift - {1'b0, dvs} : rem_shift;
            quo <= {quo[WIDTH-2:0], fits};
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n) valid |=> !valid)
        else $error("div_unit valid held longer than one cycle");

endmodule

// ==== hw/exe_bus_pkg.sv ====
package exe_bus_pkg;

    import exe_op_pkg::*;

    typedef struct packed {
        exe_fun_t exe_fun;
        word_t    op1_data;
        word_t    op2_data;
        word_t    rs2_data;   // store data for the memory stage
        word_t    imm_b_sext;
        word_t    imm_j_sext;
        logic     jmp_flg;
    } exe_ctrl_t;

    typedef struct packed {
        word_t     reg_pc;
        word_t     inst;
        inst_id_t  inst_id;
        exe_ctrl_t ctrl;
    } exe_in_t;

    typedef struct packed {
        word_t     reg_pc;
        word_t     inst;
        inst_id_t  inst_id;
        exe_ctrl_t ctrl;
        word_t     alu_out;
    } exe_mem_t;

endpackage

// ==== hw/exe_defs.svh ====
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// architectural data word
`define XLEN 32

// sequence number handed down by decode
`define INST_ID_W 64

// function code field
`define EXE_FUN_W 5

// arithmetic unit operand width
// one extra bit for sign extension, so mulhsu and signed div overflow need no special case
`define MD_W 33

`endif

// ==== hw/exe_op_pkg.sv ====
`include "exe_defs.svh"

package exe_op_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`INST_ID_W-1:0] inst_id_t;
    typedef logic [`EXE_FUN_W-1:0] exe_fun_t;

    localparam exe_fun_t ALU_ADD    = exe_fun_t'(0);
    localparam exe_fun_t ALU_SUB    = exe_fun_t'(1);
    localparam exe_fun_t ALU_AND    = exe_fun_t'(2);
    localparam exe_fun_t ALU_OR     = exe_fun_t'(3);
    localparam exe_fun_t ALU_XOR    = exe_fun_t'(4);
    localparam exe_fun_t ALU_SLL    = exe_fun_t'(5);
    localparam exe_fun_t ALU_SRL    = exe_fun_t'(6);
    localparam exe_fun_t ALU_SRA    = exe_fun_t'(7);
    localparam exe_fun_t ALU_SLT    = exe_fun_t'(8);
    localparam exe_fun_t ALU_SLTU   = exe_fun_t'(9);
    localparam exe_fun_t ALU_JALR   = exe_fun_t'(10);
    localparam exe_fun_t ALU_COPY1  = exe_fun_t'(11);
    localparam exe_fun_t ALU_MUL    = exe_fun_t'(12); // multicycle from here
    localparam exe_fun_t ALU_MULH   = exe_fun_t'(13);
    localparam exe_fun_t ALU_MULHU  = exe_fun_t'(14);
    localparam exe_fun_t ALU_MULHSU = exe_fun_t'(15);
    localparam exe_fun_t ALU_DIV    = exe_fun_t'(16);
    localparam exe_fun_t ALU_DIVU   = exe_fun_t'(17);
    localparam exe_fun_t ALU_REM    = exe_fun_t'(18);
    localparam exe_fun_t ALU_REMU   = exe_fun_t'(19);
    localparam exe_fun_t BR_BEQ     = exe_fun_t'(20);
    localparam exe_fun_t BR_BNE     = exe_fun_t'(21);
    localparam exe_fun_t BR_BLT     = exe_fun_t'(22);
    localparam exe_fun_t BR_BGE     = exe_fun_t'(23);
    localparam exe_fun_t BR_BLTU    = exe_fun_t'(24);
    localparam exe_fun_t BR_BGEU    = exe_fun_t'(25);

    typedef enum logic {MUL_IDLE, MUL_BUSY} mul_state_t;
    typedef enum logic {DIV_IDLE, DIV_BUSY} div_state_t;

endpackage

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  exe_valid,
    input  exe_bus_pkg::exe_in_t  exe_in,
    input  logic                  pipeline_flush,
    output logic                  mem_valid,
    output exe_bus_pkg::exe_mem_t mem_out,
    output logic                  calc_stall
);
    import exe_op_pkg::*;
    import exe_bus_pkg::*;

    exe_ctrl_t  ctrl;
    exe_fun_t   exe_fun;
    word_t      op1_data;
    word_t      op2_data;
    word_t      alu_out;
    word_t      md_result;
    word_t      saved_result;
    inst_id_t   saved_inst_id;
    logic       is_mul;
    logic       is_div;
    logic       is_multi;
    logic       calc_started;
    logic       is_calculated;
    logic       new_inst;
    logic       calc_valid;

    logic               mul_start;
    logic               mul_signed;
    logic               mul_ready;
    logic               mul_valid;
    logic [`MD_W-1:0]   mul_a;
    logic [`MD_W-1:0]   mul_b;
    logic [2*`MD_W-1:0] mul_product;

    logic               div_start;
    logic               div_signed;
    logic               div_ready;
    logic               div_valid;
    logic               div_error;
    logic [`MD_W-1:0]   div_a;
    logic [`MD_W-1:0]   div_b;
    logic [`MD_W-1:0]   div_quotient;
    logic [`MD_W-1:0]   div_remainder;

    assign ctrl     = exe_in.ctrl;
    assign exe_fun  = ctrl.exe_fun;
    assign op1_data = ctrl.op1_data;
    assign op2_data = ctrl.op2_data;

    assign is_mul   = exe_fun inside {ALU_MUL, ALU_MULH, ALU_MULHU, ALU_MULHSU};
    assign is_div   = exe_fun inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign is_multi = is_mul || is_div;

    // result already held for this inst_id means no restart
    assign new_inst = !is_calculated || (saved_inst_id != exe_in.inst_id);

    assign mul_signed = exe_fun inside {ALU_MUL, ALU_MULH, ALU_MULHSU};
    assign mul_a      = {mul_signed & op1_data[`XLEN-1], op1_data};
    assign mul_b      = {mul_signed & (exe_fun != ALU_MULHSU) & op2_data[`XLEN-1], op2_data};
    assign mul_start  = exe_valid && is_mul && new_inst && !calc_started && mul_ready
                        && !pipeline_flush;

    assign div_signed = exe_fun inside {ALU_DIV, ALU_REM};
    assign div_a      = {div_signed & op1_data[`XLEN-1], op1_data};
    assign div_b      = {div_signed & op2_data[`XLEN-1], op2_data};
    assign div_start  = exe_valid && is_div && new_inst && !calc_started && div_ready
                        && !pipeline_flush;

    // a late result of a flushed op finds calc_started low
    assign calc_valid = exe_valid && calc_started && ((is_mul && mul_valid) || (is_div && div_valid));

    mul_unit #(.WIDTH(`MD_W)) i_mul_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (mul_start),
        .is_signed    (mul_signed),
        .multiplicand (mul_a),
        .multiplier   (mul_b),
        .ready        (mul_ready),
        .valid        (mul_valid),
        .product      (mul_product)
    );

    div_unit #(.WIDTH(`MD_W)) i_div_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (div_a),
        .divisor   (div_b),
        .ready     (div_ready),
        .valid     (div_valid),
        .error     (div_error),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    always_comb begin
        case (exe_fun)
            ALU_MUL:           md_result = mul_product[`XLEN-1:0];
            ALU_DIV, ALU_DIVU: md_result = div_error ? '1 : div_quotient[`XLEN-1:0];
            ALU_REM, ALU_REMU: md_result = div_error ? op1_data : div_remainder[`XLEN-1:0];
            default:           md_result = mul_product[2*`XLEN-1:`XLEN]; // mulh variants
        endcase
    end

    always_comb begin
        case (exe_fun)
            ALU_ADD:   alu_out = op1_data + op2_data;
            ALU_SUB:   alu_out = op1_data - op2_data;
            ALU_AND:   alu_out = op1_data & op2_data;
            ALU_OR:    alu_out = op1_data | op2_data;
            ALU_XOR:   alu_out = op1_data ^ op2_data;
            ALU_SLL:   alu_out = op1_data << op2_data[4:0];
            ALU_SRL:   alu_out = op1_data >> op2_data[4:0];
            ALU_SRA:   alu_out = $unsigned($signed(op1_data) >>> op2_data[4:0]);
            ALU_SLT:   alu_out = word_t'($signed(op1_data) < $signed(op2_data));
            ALU_SLTU:  alu_out = word_t'(op1_data < op2_data);
            ALU_JALR:  alu_out = (op1_data + op2_data) & ~word_t'(1);
            ALU_COPY1: alu_out = op1_data;
            default:   alu_out = saved_result; // multicycle and branches
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            calc_started  <= 1'b0;
            is_calculated <= 1'b0;
            saved_inst_id <= '0;
            saved_result  <= '0;
        end else if (pipeline_flush) begin
            calc_started  <= 1'b0; // busy unit runs on unobserved
            is_calculated <= 1'b0;
        end else if (mul_start || div_start) begin
            calc_started  <= 1'b1;
            is_calculated <= 1'b0;
            saved_inst_id <= exe_in.inst_id;
        end else if (calc_valid) begin
            calc_started  <= 1'b0;
            is_calculated <= 1'b1;
            saved_result  <= md_result;
        end else if (!exe_valid || !is_multi) begin
            calc_started  <= 1'b0; // instruction withdrawn
        end
    end

    assign calc_stall = exe_valid && is_multi && new_inst;
    assign mem_valid  = exe_valid && !calc_stall;

    assign mem_out.reg_pc  = exe_in.reg_pc;
    assign mem_out.inst    = exe_in.inst;
    assign mem_out.inst_id = exe_in.inst_id;
    assign mem_out.ctrl    = ctrl;
    assign mem_out.alu_out = alu_out;

    // stalled instruction stays put unless flushed
    a_hold_during_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        calc_stall |=> pipeline_flush || (exe_valid && $stable(exe_in))
    ) else $error("exe_in changed during calc_stall");

endmodule

// ==== hw/execute_top.sv ====
`timescale 1ns/1ps

module execute_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  exe_valid,
    input  exe_bus_pkg::exe_in_t  exe_in,
    input  logic                  pipeline_flush,
    output logic                  mem_valid,
    output exe_bus_pkg::exe_mem_t mem_out,
    output logic                  calc_stall,
    output logic                  branch_hazard,
    output exe_op_pkg::word_t     branch_target
);

    // alu and muldiv path toward the memory stage
    execute_stage i_execute_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .exe_valid      (exe_valid),
        .exe_in         (exe_in),
        .pipeline_flush (pipeline_flush),
        .mem_valid      (mem_valid),
        .mem_out        (mem_out),
        .calc_stall     (calc_stall)
    );

    // redirect toward fetch, purely combinational
    branch_unit i_branch_unit (
        .exe_valid     (exe_valid),
        .exe_in        (exe_in),
        .branch_hazard (branch_hazard),
        .branch_target (branch_target)
    );

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module mul_unit #(
    parameter int WIDTH = `MD_W
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic               is_signed,
    input  logic [WIDTH-1:0]   multiplicand,
    input  logic [WIDTH-1:0]   multiplier,
    output logic               ready,
    output logic               valid,
    output logic [2*WIDTH-1:0] product
);
    import exe_op_pkg::*;

    localparam int CNT_W = $clog2(WIDTH + 1);

    mul_state_t         state;
    logic [CNT_W-1:0]   count;
    logic               signed_op;
    logic               last_bit;
    logic [2*WIDTH-1:0] acc;
    logic [2*WIDTH-1:0] mcand;   // shifted left once per step
    logic [WIDTH-1:0]   mplier;  // shifted right once per step
    logic [2*WIDTH-1:0] addend;

    assign ready    = (state == MUL_IDLE);
    assign last_bit = (count == CNT_W'(WIDTH - 1));
    // msb of a signed multiplier weighs -2^(WIDTH-1), so subtract there
    assign addend   = (signed_op && last_bit) ? -mcand : mcand;
    assign product  = acc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= MUL_IDLE;
            count <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                MUL_IDLE: begin
                    if (start) begin
                        state <= MUL_BUSY;
                        count <= '0;
                    end
                end
                MUL_BUSY: begin
                    if (count == CNT_W'(WIDTH)) begin // extra cycle to present result
                        state <= MUL_IDLE;
                        valid <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            signed_op <= is_signed;
            acc       <= '0;
            mcand     <= {{WIDTH{is_signed & multiplicand[WIDTH-1]}}, multiplicand};
            mplier    <= multiplier;
        end else if (state == MUL_BUSY && count < CNT_W'(WIDTH)) begin
            if (mplier[0]) begin
                acc <= acc + addend;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_start_when_ready: assert property (@(posedge clk) disable iff (!arst_n) start |-> ready)
        else $error("mul_unit started while busy");

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --assert -f sources.f --top-module tb_execute_top -o sim_execute

./obj_dir/sim_execute > sim.log
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sources.f ====
+incdir+hw
hw/exe_op_pkg.sv
hw/exe_bus_pkg.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/execute_stage.sv
hw/branch_unit.sv
hw/execute_top.sv
bench/clk_gen.sv
bench/tb_execute_top.sv
